// File: design/axi_endpoint_config.svh
// Bus widths and register window of the AXI endpoint
// Included by every design file that sizes a port or decodes an address
`ifndef AXI_ENDPOINT_CONFIG_SVH
`define AXI_ENDPOINT_CONFIG_SVH

`define AXI_ID_WIDTH   4
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_LEN_WIDTH  8

// Register bank size and the byte address of its first word
`define REG_COUNT      8
`define REG_BASE       32'h0000_1000

`endif

// File: design/axi_endpoint_pkg.sv
// Types shared by the AXI endpoint decoder, its targets and the top level
// Response codes follow the AXI encoding

package axi_endpoint_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // Which target a locked route points at
    typedef enum logic {
        TARGET_REGS = 1'b0,
        TARGET_TERM = 1'b1
    } target_t;

endpackage

// File: design/axi_endpoint_decoder.sv
// Address decoder of the AXI endpoint
// Steers write and read channels to the register bank or the terminator and
// keeps each route locked until the response of the transaction has transferred
`timescale 1ns/1ps
`include "axi_endpoint_config.svh"

module axi_endpoint_decoder (
    input  logic                         clock,
    input  logic                         reset,
    // Master side
    input  logic                         aw_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     aw_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   aw_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]    aw_len,
    output logic                         aw_ready,
    input  logic                         w_valid,
    input  logic [`AXI_DATA_WIDTH-1:0]   w_data,
    input  logic [`AXI_DATA_WIDTH/8-1:0] w_strb,
    input  logic                         w_last,
    output logic                         w_ready,
    output logic                         b_valid,
    output logic [`AXI_ID_WIDTH-1:0]     b_id,
    output axi_endpoint_pkg::axi_resp_t  b_resp,
    input  logic                         b_ready,
    input  logic                         ar_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     ar_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ar_addr,
    output logic                         ar_ready,
    output logic                         r_valid,
    output logic [`AXI_ID_WIDTH-1:0]     r_id,
    output logic [`AXI_DATA_WIDTH-1:0]   r_data,
    output axi_endpoint_pkg::axi_resp_t  r_resp,
    input  logic                         r_ready,
    // Target side, register bank and terminator side by side
    output logic                         regs_aw_valid, term_aw_valid,
    output logic [`AXI_ID_WIDTH-1:0]     regs_aw_id, term_aw_id,
    output logic [`AXI_ADDR_WIDTH-1:0]   regs_aw_addr, term_aw_addr,
    output logic [`AXI_LEN_WIDTH-1:0]    term_aw_len,
    input  logic                         regs_aw_ready, term_aw_ready,
    output logic                         regs_w_valid, term_w_valid,
    output logic [`AXI_DATA_WIDTH-1:0]   regs_w_data, term_w_data,
    output logic [`AXI_DATA_WIDTH/8-1:0] regs_w_strb, term_w_strb,
    output logic                         regs_w_last, term_w_last,
    input  logic                         regs_w_ready, term_w_ready,
    input  logic                         regs_b_valid, term_b_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     regs_b_id, term_b_id,
    input  axi_endpoint_pkg::axi_resp_t  regs_b_resp, term_b_resp,
    output logic                         regs_b_ready, term_b_ready,
    output logic                         regs_ar_valid, term_ar_valid,
    output logic [`AXI_ID_WIDTH-1:0]     regs_ar_id, term_ar_id,
    output logic [`AXI_ADDR_WIDTH-1:0]   regs_ar_addr, term_ar_addr,
    input  logic                         regs_ar_ready, term_ar_ready,
    input  logic                         regs_r_valid, term_r_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     regs_r_id, term_r_id,
    input  logic [`AXI_DATA_WIDTH-1:0]   regs_r_data, term_r_data,
    input  axi_endpoint_pkg::axi_resp_t  regs_r_resp, term_r_resp,
    output logic                         regs_r_ready, term_r_ready
);

    import axi_endpoint_pkg::*;

    localparam logic [`AXI_ADDR_WIDTH-1:0] REG_LIMIT =
        `REG_BASE + `REG_COUNT * (`AXI_DATA_WIDTH / 8);

    logic    wr_busy;
    target_t wr_target;
    logic    rd_busy;
    target_t rd_target;
    target_t aw_target;
    target_t ar_target;
    logic    wr_regs;
    logic    rd_regs;

    assign aw_target = (aw_addr >= `REG_BASE && aw_addr < REG_LIMIT) ? TARGET_REGS : TARGET_TERM;
    assign ar_target = (ar_addr >= `REG_BASE && ar_addr < REG_LIMIT) ? TARGET_REGS : TARGET_TERM;

    // An idle route follows the address, a locked one its captured target
    assign wr_regs = wr_busy ? (wr_target == TARGET_REGS) : (aw_target == TARGET_REGS);
    assign rd_regs = rd_busy ? (rd_target == TARGET_REGS) : (ar_target == TARGET_REGS);

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_busy   <= 1'b0;
            wr_target <= TARGET_REGS;
        end else if (aw_valid && aw_ready) begin
            wr_busy   <= 1'b1;
            wr_target <= aw_target;
        end else if (b_valid && b_ready) begin
            wr_busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_busy   <= 1'b0;
            rd_target <= TARGET_REGS;
        end else if (ar_valid && ar_ready) begin
            rd_busy   <= 1'b1;
            rd_target <= ar_target;
        end else if (r_valid && r_ready) begin
            rd_busy <= 1'b0;
        end
    end

    // Payloads fan out to both targets, only the selected one sees valid
    assign regs_aw_valid = aw_valid && wr_regs;
    assign term_aw_valid = aw_valid && !wr_regs;
    assign regs_aw_id    = aw_id;
    assign term_aw_id    = aw_id;
    assign regs_aw_addr  = aw_addr;
    assign term_aw_addr  = aw_addr;
    assign term_aw_len   = aw_len;
    assign aw_ready      = wr_regs ? regs_aw_ready : term_aw_ready;

    assign regs_w_valid = w_valid && wr_regs;
    assign term_w_valid = w_valid && !wr_regs;
    assign regs_w_data  = w_data;
    assign term_w_data  = w_data;
    assign regs_w_strb  = w_strb;
    assign term_w_strb  = w_strb;
    assign regs_w_last  = w_last;
    assign term_w_last  = w_last;
    assign w_ready      = wr_regs ? regs_w_ready : term_w_ready;

    assign b_valid      = wr_regs ? regs_b_valid : term_b_valid;
    assign b_id         = wr_regs ? regs_b_id : term_b_id;
    assign b_resp       = wr_regs ? regs_b_resp : term_b_resp;
    assign regs_b_ready = b_ready && wr_regs;
    assign term_b_ready = b_ready && !wr_regs;

    assign regs_ar_valid = ar_valid && rd_regs;
    assign term_ar_valid = ar_valid && !rd_regs;
    assign regs_ar_id    = ar_id;
    assign term_ar_id    = ar_id;
    assign regs_ar_addr  = ar_addr;
    assign term_ar_addr  = ar_addr;
    assign ar_ready      = rd_regs ? regs_ar_ready : term_ar_ready;

    assign r_valid      = rd_regs ? regs_r_valid : term_r_valid;
    assign r_id         = rd_regs ? regs_r_id : term_r_id;
    assign r_data       = rd_regs ? regs_r_data : term_r_data;
    assign r_resp       = rd_regs ? regs_r_resp : term_r_resp;
    assign regs_r_ready = r_ready && rd_regs;
    assign term_r_ready = r_ready && !rd_regs;

    // The write route stays put until its response has been accepted
    wr_route_held : assert property (@(posedge clock) disable iff (!reset)
        wr_busy && !(b_valid && b_ready) |=> wr_busy && $stable(wr_target));

    // Only the locked target may complete a write
    // The other target never holds a response of its own meanwhile
    b_from_locked : assert property (@(posedge clock) disable iff (!reset)
        b_valid && b_ready |->
            wr_busy && !((wr_target == TARGET_REGS) ? term_b_valid : regs_b_valid));

endmodule

// File: design/axi_register_bank.sv
// AXI target holding the control registers of the endpoint
// Write bursts step through the bank word by word and wrap at its end,
// reads are single beat and return the addressed register
`timescale 1ns/1ps
`include "axi_endpoint_config.svh"

module axi_register_bank (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         aw_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     aw_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   aw_addr,
    output logic                         aw_ready,
    input  logic                         w_valid,
    input  logic [`AXI_DATA_WIDTH-1:0]   w_data,
    input  logic [`AXI_DATA_WIDTH/8-1:0] w_strb,
    input  logic                         w_last,
    output logic                         w_ready,
    output logic                         b_valid,
    output logic [`AXI_ID_WIDTH-1:0]     b_id,
    output axi_endpoint_pkg::axi_resp_t  b_resp,
    input  logic                         b_ready,
    input  logic                         ar_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     ar_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ar_addr,
    output logic                         ar_ready,
    output logic                         r_valid,
    output logic [`AXI_ID_WIDTH-1:0]     r_id,
    output logic [`AXI_DATA_WIDTH-1:0]   r_data,
    output axi_endpoint_pkg::axi_resp_t  r_resp,
    input  logic                         r_ready
);

    import axi_endpoint_pkg::*;

    localparam int STRB_WIDTH  = `AXI_DATA_WIDTH / 8;
    localparam int BYTE_OFFSET = $clog2(STRB_WIDTH);
    localparam int INDEX_WIDTH = $clog2(`REG_COUNT);

    logic [`AXI_DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic [INDEX_WIDTH-1:0]     wr_index;
    logic [INDEX_WIDTH-1:0]     rd_index;
    logic                       wr_busy;
    logic                       rd_busy;
    logic                       aw_take;
    logic                       ar_take;

    // A write wins when both requests arrive at an idle bank
    assign aw_take = aw_valid && !aw_ready && !wr_busy && !rd_busy;
    assign ar_take = ar_valid && !ar_ready && !wr_busy && !rd_busy && !aw_take;

    always_ff @(posedge clock) begin
        if (!reset) begin
            aw_ready <= 1'b0;
            wr_busy  <= 1'b0;
        end else begin
            aw_ready <= aw_take;
            if (aw_take) begin
                wr_busy <= 1'b1;
            end else if (b_valid && b_ready) begin
                wr_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            w_ready <= 1'b0;
        end else if (w_valid && w_ready && w_last) begin
            w_ready <= 1'b0;
        end else if (!w_ready && w_valid && wr_busy && !b_valid) begin
            w_ready <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            b_valid <= 1'b0;
        end else if (w_valid && w_ready && w_last) begin
            b_valid <= 1'b1;
        end else if (b_valid && b_ready) begin
            b_valid <= 1'b0;
        end
    end

    // Burst index starts at the AW address and moves on with every beat
    always_ff @(posedge clock) begin
        if (aw_valid && aw_ready) begin
            b_id     <= aw_id;
            wr_index <= aw_addr[BYTE_OFFSET +: INDEX_WIDTH];
        end else if (w_valid && w_ready) begin
            wr_index <= wr_index + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (w_valid && w_ready) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (w_strb[b]) begin
                    regs[wr_index][8*b +: 8] <= w_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            ar_ready <= 1'b0;
            rd_busy  <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            ar_ready <= ar_take;
            if (ar_take) begin
                rd_busy <= 1'b1;
            end else if (r_valid && r_ready) begin
                rd_busy <= 1'b0;
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end else if (rd_busy && !r_valid) begin
                r_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ar_valid && ar_ready) begin
            r_id     <= ar_id;
            rd_index <= ar_addr[BYTE_OFFSET +: INDEX_WIDTH];
        end
    end

    // No write runs during a read, so the addressed word is stable
    assign r_data = regs[rd_index];
    assign b_resp = OKAY;
    assign r_resp = OKAY;

    w_ready_in_write : assert property (@(posedge clock) disable iff (!reset)
        w_ready |-> wr_busy && !rd_busy);

endmodule

// File: design/axi_terminator.sv
// AXI target for every address outside the register window
// Writes of any burst length are acknowledged and dropped, reads return a
// single beat of zero data, and both answer OKAY with the request ID
`timescale 1ns/1ps
`include "axi_endpoint_config.svh"

module axi_terminator (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         aw_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     aw_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   aw_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]    aw_len,
    output logic                         aw_ready,
    input  logic                         w_valid,
    input  logic [`AXI_DATA_WIDTH-1:0]   w_data,
    input  logic [`AXI_DATA_WIDTH/8-1:0] w_strb,
    input  logic                         w_last,
    output logic                         w_ready,
    output logic                         b_valid,
    output logic [`AXI_ID_WIDTH-1:0]     b_id,
    output axi_endpoint_pkg::axi_resp_t  b_resp,
    input  logic                         b_ready,
    input  logic                         ar_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     ar_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ar_addr,
    output logic                         ar_ready,
    output logic                         r_valid,
    output logic [`AXI_ID_WIDTH-1:0]     r_id,
    output logic [`AXI_DATA_WIDTH-1:0]   r_data,
    output axi_endpoint_pkg::axi_resp_t  r_resp,
    input  logic                         r_ready
);

    import axi_endpoint_pkg::*;

    logic                      wr_busy;
    logic                      rd_busy;
    logic                      aw_take;
    logic                      ar_take;
    logic [`AXI_LEN_WIDTH-1:0] len_q;
    logic [`AXI_LEN_WIDTH-1:0] beat_count;

    assign aw_take = aw_valid && !aw_ready && !wr_busy && !rd_busy;
    assign ar_take = ar_valid && !ar_ready && !wr_busy && !rd_busy && !aw_take;

    always_ff @(posedge clock) begin
        if (!reset) begin
            aw_ready   <= 1'b0;
            ar_ready   <= 1'b0;
            wr_busy    <= 1'b0;
            rd_busy    <= 1'b0;
            w_ready    <= 1'b0;
            b_valid    <= 1'b0;
            r_valid    <= 1'b0;
            beat_count <= '0;
        end else begin
            aw_ready <= aw_take;
            ar_ready <= ar_take;
            if (aw_take) begin
                wr_busy <= 1'b1;
            end else if (b_valid && b_ready) begin
                wr_busy <= 1'b0;
            end
            if (ar_take) begin
                rd_busy <= 1'b1;
            end else if (r_valid && r_ready) begin
                rd_busy <= 1'b0;
            end
            // W beats are swallowed until the last one
            if (w_valid && w_ready && w_last) begin
                w_ready <= 1'b0;
                b_valid <= 1'b1;
            end else begin
                if (!w_ready && w_valid && wr_busy && !b_valid) begin
                    w_ready <= 1'b1;
                end
                if (b_valid && b_ready) begin
                    b_valid <= 1'b0;
                end
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end else if (rd_busy && !r_valid) begin
                r_valid <= 1'b1;
            end
            if (aw_valid && aw_ready) begin
                beat_count <= '0;
            end else if (w_valid && w_ready) begin
                beat_count <= beat_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (aw_valid && aw_ready) begin
            b_id  <= aw_id;
            len_q <= aw_len;
        end
        if (ar_valid && ar_ready) begin
            r_id <= ar_id;
        end
    end

    assign r_data = '0;
    assign b_resp = OKAY;
    assign r_resp = OKAY;

    // Burst of aw_len + 1 beats ends with w_last on its final beat only
    w_last_on_len : assert property (@(posedge clock) disable iff (!reset)
        w_valid && w_ready |-> (w_last == (beat_count == len_q)));

    b_held : assert property (@(posedge clock) disable iff (!reset)
        b_valid && !b_ready |=> b_valid && $stable(b_id));

endmodule

// File: design/axi_endpoint.sv
// Top level of the AXI slave endpoint
// One master port, decoded onto the register bank and the terminator
`timescale 1ns/1ps
`include "axi_endpoint_config.svh"

module axi_endpoint (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         aw_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     aw_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   aw_addr,
    input  logic [`AXI_LEN_WIDTH-1:0]    aw_len,
    output logic                         aw_ready,
    input  logic                         w_valid,
    input  logic [`AXI_DATA_WIDTH-1:0]   w_data,
    input  logic [`AXI_DATA_WIDTH/8-1:0] w_strb,
    input  logic                         w_last,
    output logic                         w_ready,
    output logic                         b_valid,
    output logic [`AXI_ID_WIDTH-1:0]     b_id,
    output axi_endpoint_pkg::axi_resp_t  b_resp,
    input  logic                         b_ready,
    input  logic                         ar_valid,
    input  logic [`AXI_ID_WIDTH-1:0]     ar_id,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ar_addr,
    output logic                         ar_ready,
    output logic                         r_valid,
    output logic [`AXI_ID_WIDTH-1:0]     r_id,
    output logic [`AXI_DATA_WIDTH-1:0]   r_data,
    output axi_endpoint_pkg::axi_resp_t  r_resp,
    input  logic                         r_ready
);

    import axi_endpoint_pkg::*;

    logic                         regs_aw_valid, regs_aw_ready, term_aw_valid, term_aw_ready;
    logic [`AXI_ID_WIDTH-1:0]     regs_aw_id, term_aw_id, regs_ar_id, term_ar_id;
    logic [`AXI_ADDR_WIDTH-1:0]   regs_aw_addr, term_aw_addr, regs_ar_addr, term_ar_addr;
    logic [`AXI_LEN_WIDTH-1:0]    term_aw_len;
    logic                         regs_w_valid, regs_w_last, regs_w_ready;
    logic                         term_w_valid, term_w_last, term_w_ready;
    logic [`AXI_DATA_WIDTH-1:0]   regs_w_data, term_w_data, regs_r_data, term_r_data;
    logic [`AXI_DATA_WIDTH/8-1:0] regs_w_strb, term_w_strb;
    logic                         regs_b_valid, regs_b_ready, term_b_valid, term_b_ready;
    logic [`AXI_ID_WIDTH-1:0]     regs_b_id, term_b_id, regs_r_id, term_r_id;
    axi_resp_t                    regs_b_resp, term_b_resp, regs_r_resp, term_r_resp;
    logic                         regs_ar_valid, regs_ar_ready, term_ar_valid, term_ar_ready;
    logic                         regs_r_valid, regs_r_ready, term_r_valid, term_r_ready;

    // Port names on the decoder match the top ports and the wires above
    axi_endpoint_decoder u_decoder (.*);

    axi_register_bank u_regs (
        .clock    (clock),
        .reset    (reset),
        .aw_valid (regs_aw_valid),
        .aw_id    (regs_aw_id),
        .aw_addr  (regs_aw_addr),
        .aw_ready (regs_aw_ready),
        .w_valid  (regs_w_valid),
        .w_data   (regs_w_data),
        .w_strb   (regs_w_strb),
        .w_last   (regs_w_last),
        .w_ready  (regs_w_ready),
        .b_valid  (regs_b_valid),
        .b_id     (regs_b_id),
        .b_resp   (regs_b_resp),
        .b_ready  (regs_b_ready),
        .ar_valid (regs_ar_valid),
        .ar_id    (regs_ar_id),
        .ar_addr  (regs_ar_addr),
        .ar_ready (regs_ar_ready),
        .r_valid  (regs_r_valid),
        .r_id     (regs_r_id),
        .r_data   (regs_r_data),
        .r_resp   (regs_r_resp),
        .r_ready  (regs_r_ready)
    );

    axi_terminator u_term (
        .clock    (clock),
        .reset    (reset),
        .aw_valid (term_aw_valid),
        .aw_id    (term_aw_id),
        .aw_addr  (term_aw_addr),
        .aw_len   (term_aw_len),
        .aw_ready (term_aw_ready),
        .w_valid  (term_w_valid),
        .w_data   (term_w_data),
        .w_strb   (term_w_strb),
        .w_last   (term_w_last),
        .w_ready  (term_w_ready),
        .b_valid  (term_b_valid),
        .b_id     (term_b_id),
        .b_resp   (term_b_resp),
        .b_ready  (term_b_ready),
        .ar_valid (term_ar_valid),
        .ar_id    (term_ar_id),
        .ar_addr  (term_ar_addr),
        .ar_ready (term_ar_ready),
        .r_valid  (term_r_valid),
        .r_id     (term_r_id),
        .r_data   (term_r_data),
        .r_resp   (term_r_resp),
        .r_ready  (term_r_ready)
    );

endmodule

// File: verification/axi_endpoint_tb.sv
// Testbench for the AXI slave endpoint
// Acts as the bus master, keeps a shadow copy of the register bank and lets
// concurrent assertions check every write and read response
`timescale 1ns/1ps
`include "axi_endpoint_config.svh"

module axi_endpoint_tb;

    import axi_endpoint_pkg::*;

    localparam int STRB_WIDTH     = `AXI_DATA_WIDTH / 8;
    localparam int ID_COUNT       = 1 << `AXI_ID_WIDTH;
    localparam int TRANSACTIONS   = 54;
    localparam int TIMEOUT_CYCLES = TRANSACTIONS * 40 + 500;

    logic                         clock;
    logic                         reset;
    logic                         aw_valid;
    logic [`AXI_ID_WIDTH-1:0]     aw_id;
    logic [`AXI_ADDR_WIDTH-1:0]   aw_addr;
    logic [`AXI_LEN_WIDTH-1:0]    aw_len;
    logic                         aw_ready;
    logic                         w_valid;
    logic [`AXI_DATA_WIDTH-1:0]   w_data;
    logic [STRB_WIDTH-1:0]        w_strb;
    logic                         w_last;
    logic                         w_ready;
    logic                         b_valid;
    logic [`AXI_ID_WIDTH-1:0]     b_id;
    axi_resp_t                    b_resp;
    logic                         b_ready;
    logic                         ar_valid;
    logic [`AXI_ID_WIDTH-1:0]     ar_id;
    logic [`AXI_ADDR_WIDTH-1:0]   ar_addr;
    logic                         ar_ready;
    logic                         r_valid;
    logic [`AXI_ID_WIDTH-1:0]     r_id;
    logic [`AXI_DATA_WIDTH-1:0]   r_data;
    axi_resp_t                    r_resp;
    logic                         r_ready;

    // Expected response of the write and the read currently in flight
    logic [`AXI_ID_WIDTH-1:0]     exp_b_id;
    logic [`AXI_ID_WIDTH-1:0]     exp_r_id;
    logic [`AXI_DATA_WIDTH-1:0]   exp_r_data;
    logic [`AXI_DATA_WIDTH-1:0]   shadow [`REG_COUNT];
    string                        test_name;
    integer                       seed = 32'hfb9c_3aaf;
    int                           value_errors;
    int                           protocol_errors;
    int                           count_errors;
    int                           wr_issued [ID_COUNT];
    int                           wr_done [ID_COUNT];
    int                           rd_issued [ID_COUNT];
    int                           rd_done [ID_COUNT];

    axi_endpoint u_axi_endpoint (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic bit in_window(input logic [`AXI_ADDR_WIDTH-1:0] addr);
        return addr >= `REG_BASE && addr < `REG_BASE + `REG_COUNT * STRB_WIDTH;
    endfunction

    function automatic int word_index(input logic [`AXI_ADDR_WIDTH-1:0] addr);
        return (addr / STRB_WIDTH) % `REG_COUNT;
    endfunction

    // Ready low for 0 to 3 cycles once the response is up
    task automatic hold_off();
        int delay;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clock);
    endtask

    task automatic write_burst(input logic [`AXI_ID_WIDTH-1:0] id,
                               input logic [`AXI_ADDR_WIDTH-1:0] addr, input int beats,
                               input logic [`AXI_DATA_WIDTH-1:0] data,
                               input logic [STRB_WIDTH-1:0] strb);
        int idx;
        logic [`AXI_DATA_WIDTH-1:0] beat_data;
        exp_b_id = id;
        wr_issued[id]++;
        aw_valid = 1'b1;
        aw_id    = id;
        aw_addr  = addr;
        aw_len   = `AXI_LEN_WIDTH'(beats - 1);
        while (!aw_ready) @(negedge clock);
        @(negedge clock);
        aw_valid = 1'b0;
        idx = word_index(addr);
        for (int i = 0; i < beats; i++) begin
            beat_data = data + i * 32'h0101_0101;
            // Only the register window keeps the data, wrapping within the bank
            if (in_window(addr)) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (strb[b]) begin
                        shadow[idx][8*b +: 8] = beat_data[8*b +: 8];
                    end
                end
            end
            idx = (idx + 1) % `REG_COUNT;
            w_valid = 1'b1;
            w_data  = beat_data;
            w_strb  = strb;
            w_last  = (i == beats - 1);
            while (!w_ready) @(negedge clock);
            @(negedge clock);
        end
        w_valid = 1'b0;
        w_last  = 1'b0;
        while (!b_valid) @(negedge clock);
        hold_off();
        b_ready = 1'b1;
        @(negedge clock);
        b_ready = 1'b0;
    endtask

    task automatic read_single(input logic [`AXI_ID_WIDTH-1:0] id,
                               input logic [`AXI_ADDR_WIDTH-1:0] addr);
        exp_r_id   = id;
        exp_r_data = in_window(addr) ? shadow[word_index(addr)] : '0;
        rd_issued[id]++;
        ar_valid = 1'b1;
        ar_id    = id;
        ar_addr  = addr;
        while (!ar_ready) @(negedge clock);
        @(negedge clock);
        ar_valid = 1'b0;
        while (!r_valid) @(negedge clock);
        hold_off();
        r_ready = 1'b1;
        @(negedge clock);
        r_ready = 1'b0;
    endtask

    always @(posedge clock) begin
        if (reset && b_valid && b_ready) begin
            wr_done[b_id] <= wr_done[b_id] + 1;
        end
        if (reset && r_valid && r_ready) begin
            rd_done[r_id] <= rd_done[r_id] + 1;
        end
    end

    b_id_ok : assert property (@(posedge clock) disable iff (!reset)
        b_valid && b_ready |-> b_id == exp_b_id)
        else begin
            value_errors++;
            $display("mismatch %s b_id expected %0h actual %0h",
                     test_name, exp_b_id, $sampled(b_id));
        end

    b_resp_ok : assert property (@(posedge clock) disable iff (!reset)
        b_valid && b_ready |-> b_resp == OKAY)
        else begin
            value_errors++;
            $display("mismatch %s b_resp expected %0h actual %0h",
                     test_name, OKAY, $sampled(b_resp));
        end

    r_id_ok : assert property (@(posedge clock) disable iff (!reset)
        r_valid && r_ready |-> r_id == exp_r_id)
        else begin
            value_errors++;
            $display("mismatch %s r_id expected %0h actual %0h",
                     test_name, exp_r_id, $sampled(r_id));
        end

    r_data_ok : assert property (@(posedge clock) disable iff (!reset)
        r_valid && r_ready |-> r_data == exp_r_data && r_resp == OKAY)
        else begin
            value_errors++;
            $display("mismatch %s r_data expected %h actual %h (r_resp %0h)",
                     test_name, exp_r_data, $sampled(r_data), $sampled(r_resp));
        end

    // Back-pressured responses must neither drop nor change
    b_stable : assert property (@(posedge clock) disable iff (!reset)
        b_valid && !b_ready |=> b_valid && $stable(b_id) && $stable(b_resp))
        else begin
            protocol_errors++;
            $display("%s: write response dropped or changed while b_ready was low", test_name);
        end

    r_stable : assert property (@(posedge clock) disable iff (!reset)
        r_valid && !r_ready |=> r_valid && $stable(r_id) && $stable(r_data))
        else begin
            protocol_errors++;
            $display("%s: read response dropped or changed while r_ready was low", test_name);
        end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset    = 1'b0;
        aw_valid = 1'b0;
        aw_id    = '0;
        aw_addr  = '0;
        aw_len   = '0;
        w_valid  = 1'b0;
        w_data   = '0;
        w_strb   = '0;
        w_last   = 1'b0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar_id    = '0;
        ar_addr  = '0;
        r_ready  = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        test_name = "reset";
        repeat (10) @(posedge clock);
        @(negedge clock);
        // Every handshake output rests low out of reset
        assert (!aw_ready && !w_ready && !b_valid && !ar_ready && !r_valid) else begin
            protocol_errors++;
            $display("%s: a ready or valid output is high during reset", test_name);
        end
        reset = 1'b1;
        @(negedge clock);

        test_name = "single_writes";
        for (int i = 0; i < `REG_COUNT; i++) begin
            write_burst(`AXI_ID_WIDTH'(i), `REG_BASE + i * STRB_WIDTH, 1, $random(seed), 4'hf);
        end
        test_name = "single_reads";
        for (int i = 0; i < `REG_COUNT; i++) begin
            read_single(`AXI_ID_WIDTH'(i + 8), `REG_BASE + i * STRB_WIDTH);
        end

        test_name = "partial_strobe";
        write_burst(4'h3, `REG_BASE + 8, 1, 32'hdead_beef, 4'b0101);
        write_burst(4'h4, `REG_BASE + 20, 1, $random(seed), 4'b1000);
        read_single(4'h5, `REG_BASE + 8);
        read_single(4'h6, `REG_BASE + 20);

        // Four beats from register 6 land in 6, 7, 0 and 1
        test_name = "wrap_burst";
        write_burst(4'h7, `REG_BASE + 24, 4, 32'h1234_5678, 4'hf);
        read_single(4'h8, `REG_BASE + 24);
        read_single(4'h9, `REG_BASE + 28);
        read_single(4'ha, `REG_BASE + 0);
        read_single(4'hb, `REG_BASE + 4);

        test_name = "outside_window";
        write_burst(4'h9, `REG_BASE + `REG_COUNT * STRB_WIDTH, 1, 32'hffff_ffff, 4'hf);
        write_burst(4'ha, 32'h0000_0000, 3, 32'h5555_aaaa, 4'hf);
        write_burst(4'hb, 32'h8000_0000, 8, 32'hcafe_0000, 4'hf);
        read_single(4'hc, `REG_BASE - 4);
        read_single(4'hd, 32'h4000_0010);
        for (int i = 0; i < `REG_COUNT; i++) begin
            read_single(`AXI_ID_WIDTH'(i), `REG_BASE + i * STRB_WIDTH);
        end

        // Each pair puts a write on one target and a read on the other
        test_name = "interleaved";
        for (int k = 0; k < 8; k++) begin
            if (k % 2 == 0) begin
                fork
                    write_burst(`AXI_ID_WIDTH'($random(seed)), `REG_BASE + k * STRB_WIDTH,
                                1, $random(seed), 4'hf);
                    read_single(`AXI_ID_WIDTH'($random(seed)), 32'h2000_0000 + k * 4);
                join
            end else begin
                fork
                    write_burst(`AXI_ID_WIDTH'($random(seed)), 32'h3000_0000 + k * 4,
                                1 + k % 4, $random(seed), 4'hf);
                    read_single(`AXI_ID_WIDTH'($random(seed)), `REG_BASE + (k - 1) * STRB_WIDTH);
                join
            end
        end

        repeat (4) @(negedge clock);
        test_name = "id_counts";
        for (int id = 0; id < ID_COUNT; id++) begin
            assert (wr_done[id] == wr_issued[id]) else begin
                count_errors++;
                $display("mismatch %s write ID %0h expected %0d actual %0d",
                         test_name, id, wr_issued[id], wr_done[id]);
            end
            assert (rd_done[id] == rd_issued[id]) else begin
                count_errors++;
                $display("mismatch %s read ID %0h expected %0d actual %0d",
                         test_name, id, rd_issued[id], rd_done[id]);
            end
        end

        $display("Errors: %0d value mismatches, %0d protocol errors, %0d count errors",
                 value_errors, protocol_errors, count_errors);
        if (value_errors + protocol_errors + count_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/axi_endpoint_pkg.sv
design/axi_endpoint_decoder.sv
design/axi_register_bank.sv
design/axi_terminator.sv
design/axi_endpoint.sv
verification/axi_endpoint_tb.sv
